// File: source/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Address split of a 32-bit byte address
`define CACHE_OFFSET_BITS 5
`define CACHE_INDEX_BITS  3
`define CACHE_TAG_BITS    (32 - `CACHE_OFFSET_BITS - `CACHE_INDEX_BITS)

// Two ways per set
`define CACHE_WAYS 2

// 32-byte line
`define CACHE_LINE_BITS 256

`endif

// File: source/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

    // One cache line as exchanged with memory
    typedef logic [`CACHE_LINE_BITS-1:0] line_t;

    // Core side request, 70 bits
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [3:0]  byte_en;
        logic [31:0] wdata;
    } word_req_t;

    // Line request towards the memory port
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;     // Line aligned
        line_t       wdata;
    } line_req_t;

    // Context kept by a word lane for the request in flight
    typedef struct packed {
        logic [`CACHE_OFFSET_BITS-3:0] offset;   // Word within the line
        logic                          write;
        logic [3:0]                    byte_en;
        logic [31:0]                   wdata;
    } lane_ctx_t;

endpackage

// File: source/word_lane.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module word_lane import cache_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  word_req_t   req,
    input  logic        accept,
    input  line_t       line_in,
    output logic [31:0] word_out,
    output line_t       line_out
);

    localparam int WORD_BITS = `CACHE_OFFSET_BITS - 2;
    localparam int WORDS     = `CACHE_LINE_BITS / 32;

    lane_ctx_t   ctx;
    logic [31:0] merged_word;

    // Capture context alongside the cache address register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctx <= '0;
        end else if (accept) begin
            ctx.offset  <= req.addr[`CACHE_OFFSET_BITS-1:2];
            ctx.write   <= req.write;
            ctx.byte_en <= req.byte_en;
            ctx.wdata   <= req.wdata;
        end
    end

    assign word_out = line_in[ctx.offset*32 +: 32];

    // Store bytes over the current word
    always_comb begin
        merged_word = word_out;
        for (int b = 0; b < 4; b++) begin
            if (ctx.byte_en[b]) begin
                merged_word[b*8 +: 8] = ctx.wdata[b*8 +: 8];
            end
        end
    end

    // Reads pass the line unchanged
    always_comb begin
        for (int w = 0; w < WORDS; w++) begin
            if (ctx.write && (ctx.offset == WORD_BITS'(w))) begin
                line_out[w*32 +: 32] = merged_word;
            end else begin
                line_out[w*32 +: 32] = line_in[w*32 +: 32];
            end
        end
    end

endmodule

// File: source/cache_core.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_core import cache_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  word_req_t req,
    input  logic      stall,
    input  line_t     wline,
    output line_t     rline,
    output logic      resp,
    output logic      ready,
    output line_req_t mem_req,
    input  line_t     mem_line,
    input  logic      mem_resp
);

    localparam int OFF      = `CACHE_OFFSET_BITS;
    localparam int IDX      = `CACHE_INDEX_BITS;
    localparam int TAG      = `CACHE_TAG_BITS;
    localparam int WAYS     = `CACHE_WAYS;
    localparam int SETS     = 1 << IDX;
    localparam int WAY_BITS = $clog2(WAYS);

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        FILL,
        RESPOND
    } state_t;

    state_t state, state_next;

    line_t          data_arr  [WAYS][SETS];
    logic [TAG-1:0] tag_arr   [WAYS][SETS];
    logic [SETS-1:0] valid_arr [WAYS];
    logic [SETS-1:0] dirty_arr [WAYS];
    logic [SETS-1:0] lru;      // Way to evict next

    logic          req_valid;
    logic          req_write;
    logic [31:0]   req_addr;
    logic [IDX-1:0] idx;
    logic [TAG-1:0] req_tag;

    logic [WAYS-1:0]     match;
    logic                hit;
    logic [WAY_BITS-1:0] hit_way;
    logic [WAY_BITS-1:0] victim;
    logic                accept;
    logic                commit;
    logic                fill_done;

    assign idx     = req_addr[OFF +: IDX];
    assign req_tag = req_addr[31 -: TAG];
    assign victim  = lru[idx];

    // Tag compare on the registered address
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            match[w] = valid_arr[w][idx] && (tag_arr[w][idx] == req_tag);
            if (match[w]) begin
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign hit    = |match;
    assign rline  = data_arr[hit_way][idx];
    assign resp   = req_valid && hit && (state == IDLE || state == RESPOND);
    assign commit = resp && !stall;   // Response consumed this edge
    assign ready  = (state == IDLE || state == RESPOND) && (!req_valid || commit);
    assign accept = ready && (req.read || req.write);
    assign fill_done = (state == FILL) && mem_resp;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req_valid && !hit) begin
                    if (valid_arr[victim][idx] && dirty_arr[victim][idx]) begin
                        state_next = WRITEBACK;
                    end else begin
                        state_next = FILL;
                    end
                end
            end
            WRITEBACK: if (mem_resp) state_next = FILL;
            FILL:      if (mem_resp) state_next = RESPOND;
            RESPOND:   if (!stall) state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    // Held steady by the state until mem_resp
    always_comb begin
        mem_req = '0;
        case (state)
            WRITEBACK: begin
                mem_req.write = 1'b1;
                mem_req.addr  = {tag_arr[victim][idx], idx, {OFF{1'b0}}};
                mem_req.wdata = data_arr[victim][idx];
            end
            FILL: begin
                mem_req.read = 1'b1;
                mem_req.addr = {req_tag, idx, {OFF{1'b0}}};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            req_valid <= 1'b0;
            valid_arr <= '{default: '0};
            dirty_arr <= '{default: '0};
            lru       <= '0;
        end else begin
            state <= state_next;
            if (accept) begin
                req_valid <= 1'b1;
            end else if (commit) begin
                req_valid <= 1'b0;
            end
            if (fill_done) begin
                valid_arr[victim][idx] <= 1'b1;
                dirty_arr[victim][idx] <= 1'b0;
            end
            if (commit) begin
                lru[idx] <= ~hit_way;
                if (req_write) begin
                    dirty_arr[hit_way][idx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= req.addr;
            req_write <= req.write;
        end
    end

    // Store lands once, when the response is taken
    always_ff @(posedge clk) begin
        if (fill_done) begin
            data_arr[victim][idx] <= mem_line;
            tag_arr[victim][idx]  <= req_tag;
        end else if (commit && req_write) begin
            data_arr[hit_way][idx] <= wline;
        end
    end

endmodule

// File: source/cache_arbiter.sv
`timescale 1ns/10ps

module cache_arbiter import cache_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  line_req_t   d_req,
    input  line_req_t   i_req,
    output logic        d_resp,
    output logic        i_resp,
    output line_t       line_rdata,
    output logic        pmem_read,
    output logic        pmem_write,
    output logic [31:0] pmem_address,
    output line_t       pmem_wdata,
    input  logic        pmem_resp,
    input  line_t       pmem_rdata
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_DATA,
        ARB_INST
    } grant_t;

    grant_t    state;
    logic      d_pending;
    logic      i_pending;
    line_req_t sel_req;
    logic      line_valid;    // Registered line waiting for its cache

    assign d_pending = d_req.read || d_req.write;
    assign i_pending = i_req.read || i_req.write;
    assign sel_req   = d_pending ? d_req : i_req;   // Data first

    assign d_resp = (state == ARB_DATA) && line_valid;
    assign i_resp = (state == ARB_INST) && line_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ARB_IDLE;
            pmem_read  <= 1'b0;
            pmem_write <= 1'b0;
            line_valid <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (d_pending || i_pending) begin
                        state      <= d_pending ? ARB_DATA : ARB_INST;
                        pmem_read  <= sel_req.read;
                        pmem_write <= sel_req.write;
                    end
                end
                ARB_DATA, ARB_INST: begin
                    if (pmem_resp) begin
                        pmem_read  <= 1'b0;
                        pmem_write <= 1'b0;
                        line_valid <= 1'b1;
                    end else if (line_valid) begin
                        // Grant ends with the line_resp pulse
                        line_valid <= 1'b0;
                        state      <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Address and data freeze once granted
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE) begin
            pmem_address <= sel_req.addr;
            pmem_wdata   <= sel_req.wdata;
        end
        if (pmem_resp) begin
            line_rdata <= pmem_rdata;
        end
    end

endmodule

// File: source/cache_hierarchy.sv
`timescale 1ns/10ps

module cache_hierarchy import cache_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,

    input  word_req_t   imem_req,
    input  logic        imem_stall,
    output logic [31:0] imem_rdata,
    output logic        imem_resp,
    output logic        imem_ready,

    input  word_req_t   dmem_req,
    input  logic        dmem_stall,
    output logic [31:0] dmem_rdata,
    output logic        dmem_resp,
    output logic        dmem_ready,

    output logic        pmem_read,
    output logic        pmem_write,
    output logic [31:0] pmem_address,
    output line_t       pmem_wdata,
    input  logic        pmem_resp,
    input  line_t       pmem_rdata
);

    logic      imem_accept, dmem_accept;
    line_t     icache_rline, dcache_rline;
    line_t     icache_wline, dcache_wline;
    line_req_t icache_mem_req, dcache_mem_req;
    logic      icache_line_resp, dcache_line_resp;
    line_t     line_rdata;

    assign imem_accept = imem_ready && (imem_req.read || imem_req.write);
    assign dmem_accept = dmem_ready && (dmem_req.read || dmem_req.write);

    cache_core icache_core (
        .clk,
        .arst_n,
        .req      (imem_req),
        .stall    (imem_stall),
        .wline    (icache_wline),   // Never stored, no writes on this port
        .rline    (icache_rline),
        .resp     (imem_resp),
        .ready    (imem_ready),
        .mem_req  (icache_mem_req),
        .mem_line (line_rdata),
        .mem_resp (icache_line_resp)
    );

    cache_core dcache_core (
        .clk,
        .arst_n,
        .req      (dmem_req),
        .stall    (dmem_stall),
        .wline    (dcache_wline),
        .rline    (dcache_rline),
        .resp     (dmem_resp),
        .ready    (dmem_ready),
        .mem_req  (dcache_mem_req),
        .mem_line (line_rdata),
        .mem_resp (dcache_line_resp)
    );

    word_lane ilane (
        .clk,
        .arst_n,
        .req      (imem_req),
        .accept   (imem_accept),
        .line_in  (icache_rline),
        .word_out (imem_rdata),
        .line_out (icache_wline)
    );

    // Merged store line feeds back into the data array
    word_lane dlane (
        .clk,
        .arst_n,
        .req      (dmem_req),
        .accept   (dmem_accept),
        .line_in  (dcache_rline),
        .word_out (dmem_rdata),
        .line_out (dcache_wline)
    );

    cache_arbiter arbiter (
        .clk,
        .arst_n,
        .d_req        (dcache_mem_req),
        .i_req        (icache_mem_req),
        .d_resp       (dcache_line_resp),
        .i_resp       (icache_line_resp),
        .line_rdata   (line_rdata),
        .pmem_read,
        .pmem_write,
        .pmem_address,
        .pmem_wdata,
        .pmem_resp,
        .pmem_rdata
    );

endmodule

// File: testbench/main_memory_model.sv
`timescale 1ns/10ps

module main_memory_model import cache_pkg::*; #(
    parameter int LATENCY = 4
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        pmem_read,
    input  logic        pmem_write,
    input  logic [31:0] pmem_address,
    input  line_t       pmem_wdata,
    output logic        pmem_resp,
    output line_t       pmem_rdata
);

    localparam int LINES = 1024;   // 32 KB window

    line_t       stored      [LINES];
    logic [31:0] stored_addr [LINES];
    logic        written     [LINES];
    logic        busy;
    int          wait_cnt;

    // Word at byte address a holds a ^ C0DE0000
    function automatic line_t initial_line(logic [31:0] line_addr);
        line_t l;
        for (int w = 0; w < 8; w++) begin
            l[w*32 +: 32] = (line_addr + 32'(w * 4)) ^ 32'hC0DE0000;
        end
        return l;
    endfunction

    function automatic line_t read_line(logic [31:0] addr);
        int i;
        i = addr[14:5];
        if (written[i] && stored_addr[i] == addr) begin
            return stored[i];
        end
        return initial_line(addr);
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            wait_cnt   <= 0;
            pmem_resp  <= 1'b0;
            pmem_rdata <= '0;
            for (int i = 0; i < LINES; i++) begin
                written[i] <= 1'b0;
            end
        end else begin
            pmem_resp <= 1'b0;
            if (busy) begin
                if (wait_cnt == LATENCY - 1) begin
                    busy      <= 1'b0;
                    pmem_resp <= 1'b1;
                    if (pmem_write) begin
                        stored[pmem_address[14:5]]      <= pmem_wdata;
                        stored_addr[pmem_address[14:5]] <= pmem_address;
                        written[pmem_address[14:5]]     <= 1'b1;
                    end else begin
                        pmem_rdata <= read_line(pmem_address);
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end else if ((pmem_read || pmem_write) && !pmem_resp) begin
                busy     <= 1'b1;   // Request still high in the resp cycle
                wait_cnt <= 1;
            end
        end
    end

endmodule

// File: testbench/cache_hierarchy_props.sv
`timescale 1ns/10ps

module cache_hierarchy_props import cache_pkg::*; (
    input logic        clk,
    input logic        arst_n,
    input word_req_t   imem_req,
    input logic        imem_stall,
    input logic [31:0] imem_rdata,
    input logic        imem_resp,
    input logic        imem_ready,
    input word_req_t   dmem_req,
    input logic        dmem_stall,
    input logic [31:0] dmem_rdata,
    input logic        dmem_resp,
    input logic        dmem_ready,
    input logic        pmem_read,
    input logic        pmem_write,
    input logic [31:0] pmem_address,
    input logic        pmem_resp
);

    logic i_open;   // Accepted and not yet consumed
    logic d_open;
    int   failures = 0;   // Assertion failures so far

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            i_open <= 1'b0;
            d_open <= 1'b0;
        end else begin
            if (imem_ready && (imem_req.read || imem_req.write)) begin
                i_open <= 1'b1;
            end else if (imem_resp && !imem_stall) begin
                i_open <= 1'b0;
            end
            if (dmem_ready && (dmem_req.read || dmem_req.write)) begin
                d_open <= 1'b1;
            end else if (dmem_resp && !dmem_stall) begin
                d_open <= 1'b0;
            end
        end
    end

    a_pmem_one_dir: assert property (@(posedge clk) disable iff (!arst_n)
        !(pmem_read && pmem_write))
        else begin
            failures++;
            $error("pmem read and write both high");
        end

    a_iresp_req: assert property (@(posedge clk) disable iff (!arst_n)
        imem_resp |-> i_open)
        else begin
            failures++;
            $error("imem resp without an accepted request");
        end

    a_dresp_req: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_resp |-> d_open)
        else begin
            failures++;
            $error("dmem resp without an accepted request");
        end

    a_irdata_held: assert property (@(posedge clk) disable iff (!arst_n)
        imem_resp && imem_stall |=> $stable(imem_rdata))
        else begin
            failures++;
            $error("imem rdata moved in stall");
        end

    a_drdata_held: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_resp && dmem_stall |=> $stable(dmem_rdata))
        else begin
            failures++;
            $error("dmem rdata moved in stall");
        end

    a_pmem_addr_held: assert property (@(posedge clk) disable iff (!arst_n)
        (pmem_read || pmem_write) && !pmem_resp |=> $stable(pmem_address))
        else begin
            failures++;
            $error("pmem address changed before pmem resp");
        end

endmodule

bind cache_hierarchy cache_hierarchy_props props0 (.*);

// File: testbench/cache_hierarchy_tb.sv
`timescale 1ns/10ps

module cache_hierarchy_tb import cache_pkg::*; ();

    localparam int MEM_LATENCY_CYCLES  = 4;
    localparam int LONGEST_TEST_CYCLES = 400;
    localparam int TIMEOUT_CYCLES      = 10 * LONGEST_TEST_CYCLES;

    logic        clk;
    logic        arst_n;
    word_req_t   imem_req;
    word_req_t   dmem_req;
    logic        imem_stall;
    logic        dmem_stall;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_rdata;
    logic        imem_resp;
    logic        imem_ready;
    logic        dmem_resp;
    logic        dmem_ready;
    logic        pmem_read;
    logic        pmem_write;
    logic [31:0] pmem_address;
    line_t       pmem_wdata;
    logic        pmem_resp;
    line_t       pmem_rdata;

    logic [31:0] lcg_state = 32'd35433;
    logic [31:0] sh_addr [$];   // Word-aligned stores seen so far
    logic [31:0] sh_data [$];
    logic [31:0] rd_addr [$];   // Completed memory transfers
    logic [31:0] wr_addr [$];
    line_t       wr_line [$];
    string       test_name;
    int          tests;
    int          checks;
    int          errors;
    int          err_at_start;
    int          cycles;

    cache_hierarchy dut0 (.*);

    main_memory_model #(.LATENCY(MEM_LATENCY_CYCLES)) mem0 (
        .clk,
        .arst_n,
        .pmem_read,
        .pmem_write,
        .pmem_address,
        .pmem_wdata,
        .pmem_resp,
        .pmem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (arst_n && pmem_resp) begin
            if (pmem_write) begin
                wr_addr.push_back(pmem_address);
                wr_line.push_back(pmem_wdata);
            end else begin
                rd_addr.push_back(pmem_address);
            end
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Memory rule overridden by the latest store to that word
    function automatic logic [31:0] expected_word(logic [31:0] addr);
        logic [31:0] wa;
        logic [31:0] v;
        wa = {addr[31:2], 2'b00};
        v  = wa ^ 32'hC0DE0000;
        for (int i = 0; i < sh_addr.size(); i++) begin
            if (sh_addr[i] == wa) begin
                v = sh_data[i];
            end
        end
        return v;
    endfunction

    function automatic line_t expected_line(logic [31:0] line_addr);
        line_t l;
        for (int w = 0; w < 8; w++) begin
            l[w*32 +: 32] = expected_word(line_addr + 32'(w * 4));
        end
        return l;
    endfunction

    task automatic record_store(logic [31:0] addr, logic [31:0] wdata, logic [3:0] be);
        logic [31:0] v;
        v = expected_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                v[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        sh_addr.push_back({addr[31:2], 2'b00});
        sh_data.push_back(v);
    endtask

    task automatic check_word(string what, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s, %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_line(string what, line_t exp, line_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s, %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s, %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_true(logic cond, string what);
        checks++;
        if (cond !== 1'b1) begin
            errors++;
            $display("%s: %s", test_name, what);
        end
    endtask

    task automatic begin_test(string name);
        test_name    = name;
        err_at_start = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("%s %s, %0d errors", test_name,
                 (errors == err_at_start) ? "pass" : "FAIL", errors - err_at_start);
    endtask

    // lat counts cycles from acceptance to resp and is 1 on a hit
    task automatic access(input bit dport, input word_req_t r, output logic [31:0] data,
                          output int lat);
        @(negedge clk);
        if (dport) begin
            dmem_req = r;
        end else begin
            imem_req = r;
        end
        while (!(dport ? dmem_ready : imem_ready)) @(negedge clk);
        @(negedge clk);
        if (dport) begin
            dmem_req = '0;
        end else begin
            imem_req = '0;
        end
        lat = 1;
        while (!(dport ? dmem_resp : imem_resp)) begin
            @(negedge clk);
            lat++;
        end
        data = dport ? dmem_rdata : imem_rdata;
    endtask

    function automatic word_req_t make_req(logic wr, logic [31:0] addr, logic [3:0] be,
                                           logic [31:0] wdata);
        word_req_t r;
        r.read    = !wr;
        r.write   = wr;
        r.addr    = addr;
        r.byte_en = be;
        r.wdata   = wdata;
        return r;
    endfunction

    task automatic test_reset();
        begin_test("reset");
        check_bit("imem resp", 1'b0, imem_resp);
        check_bit("dmem resp", 1'b0, dmem_resp);
        check_bit("pmem read", 1'b0, pmem_read);
        check_bit("pmem write", 1'b0, pmem_write);
        check_bit("imem ready", 1'b1, imem_ready);
        check_bit("dmem ready", 1'b1, dmem_ready);
        end_test();
    endtask

    task automatic test_fetch();
        logic [31:0] a;
        logic [31:0] data;
        int          lat;
        int          reads_before;
        begin_test("fetch");
        for (int k = 0; k < 4; k++) begin
            a = 32'h1000 + 32'(k * 32) + (next_rand() & 32'h1C);
            access(1'b0, make_req(1'b0, a, 4'hF, '0), data, lat);
            check_word("first fetch", expected_word(a), data);
            check_true(lat > 1, "first fetch of a line did not miss");
            reads_before = rd_addr.size();
            a = {a[31:5], 3'(a[4:2] + 3'd1), 2'b00};   // Neighbour word in the same line
            access(1'b0, make_req(1'b0, a, 4'hF, '0), data, lat);
            check_word("second fetch", expected_word(a), data);
            check_true(lat == 1, "second fetch did not respond in the next cycle");
            check_true(rd_addr.size() == reads_before, "memory read on a hit");
        end
        end_test();
    endtask

    task automatic test_stores();
        logic [31:0] addrs [6];
        logic [31:0] wd;
        logic [31:0] rnd;
        logic [31:0] data;
        int          lat;
        begin_test("stores");
        for (int k = 0; k < 6; k++) begin
            addrs[k] = 32'h2000 | (next_rand() & 32'h7C);   // Sets 0 to 3
            wd       = next_rand();
            rnd      = next_rand();
            access(1'b1, make_req(1'b1, addrs[k], rnd[19:16], wd), data, lat);
            record_store(addrs[k], wd, rnd[19:16]);
        end
        for (int k = 0; k < 6; k++) begin
            access(1'b1, make_req(1'b0, addrs[k], 4'hF, '0), data, lat);
            check_word("load after store", expected_word(addrs[k]), data);
        end
        end_test();
    endtask

    // Three tags in set 5 push out the first dirty line
    task automatic test_evict();
        logic [31:0] a [3];
        logic [31:0] wd;
        logic [31:0] data;
        int          lat;
        int          writes_before;
        begin_test("evict");
        for (int k = 0; k < 3; k++) begin
            a[k] = 32'h30A0 + 32'(k * 32'h1000) + (next_rand() & 32'h1C);
            wd   = next_rand();
            if (k == 2) begin
                writes_before = wr_addr.size();
            end
            access(1'b1, make_req(1'b1, a[k], 4'hF, wd), data, lat);
            record_store(a[k], wd, 4'hF);
        end
        check_true(wr_addr.size() == writes_before + 1, "eviction gave no single writeback");
        check_word("writeback address", 32'h30A0, wr_addr[$]);
        check_line("writeback line", expected_line(32'h30A0), wr_line[$]);
        access(1'b1, make_req(1'b0, a[0], 4'hF, '0), data, lat);
        check_word("reload of evicted line", expected_word(a[0]), data);
        end_test();
    endtask

    task automatic test_contention();
        logic [31:0] ia;
        logic [31:0] da;
        logic [31:0] idata;
        logic [31:0] ddata;
        int          ilat;
        int          dlat;
        int          reads_before;
        begin_test("contend");
        ia = 32'h10C0 + (next_rand() & 32'h1C);
        da = 32'h60C0 + (next_rand() & 32'h1C);
        reads_before = rd_addr.size();
        fork
            access(1'b0, make_req(1'b0, ia, 4'hF, '0), idata, ilat);
            access(1'b1, make_req(1'b0, da, 4'hF, '0), ddata, dlat);
        join
        check_word("instruction word", expected_word(ia), idata);
        check_word("data word", expected_word(da), ddata);
        check_true(rd_addr.size() == reads_before + 2, "two line reads expected");
        check_word("first line read", {da[31:5], 5'b0}, rd_addr[reads_before]);
        end_test();
    endtask

    task automatic test_stall();
        logic [31:0] a;
        logic [31:0] data;
        int          lat;
        begin_test("stall");
        a = 32'h60C8;
        @(negedge clk);
        dmem_stall = 1'b1;
        access(1'b1, make_req(1'b0, a, 4'hF, '0), data, lat);
        check_word("stalled load", expected_word(a), data);
        check_true(lat == 1, "stalled load did not hit");
        repeat (5) begin
            @(negedge clk);
            check_bit("resp held", 1'b1, dmem_resp);
            check_word("rdata held", expected_word(a), dmem_rdata);
            check_bit("ready in stall", 1'b0, dmem_ready);
        end
        dmem_stall = 1'b0;
        a = 32'h60CC;
        access(1'b1, make_req(1'b0, a, 4'hF, '0), data, lat);
        check_word("load after release", expected_word(a), data);
        a = 32'h1004;
        imem_stall = 1'b1;
        access(1'b0, make_req(1'b0, a, 4'hF, '0), data, lat);
        check_word("stalled fetch", expected_word(a), data);
        repeat (3) begin
            @(negedge clk);
            check_bit("imem resp held", 1'b1, imem_resp);
            check_word("imem rdata held", expected_word(a), imem_rdata);
            check_bit("imem ready in stall", 1'b0, imem_ready);
        end
        imem_stall = 1'b0;
        end_test();
    endtask

    initial begin
        imem_req   = '0;
        dmem_req   = '0;
        imem_stall = 1'b0;
        dmem_stall = 1'b0;
        arst_n     = 1'b0;
        tests      = 0;
        checks     = 0;
        errors     = 0;
        cycles     = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_fetch();
        test_stores();
        test_evict();
        test_contention();
        test_stall();
        @(negedge clk);
        if (dut0.props0.failures != 0) begin
            $display("%0d handshake assertions failed", dut0.props0.failures);
            errors = errors + dut0.props0.failures;
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+source
source/cache_pkg.sv
source/word_lane.sv
source/cache_core.sv
source/cache_arbiter.sv
source/cache_hierarchy.sv
testbench/main_memory_model.sv
testbench/cache_hierarchy_props.sv
testbench/cache_hierarchy_tb.sv
